/* run.sh */
#!/bin/sh
# build and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f src.f \
   --top-module csr_tb \
   --Mdir obj_dir \
   -o csr_sim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit $status
fi

./obj_dir/csr_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

echo "simulation finished"
exit 0

/* src.f */
src/csr_pkg.sv
src/csr_state_if.sv
src/csr_counters.sv
src/csr_mregs.sv
src/csr_rd_mux.sv
src/csr_top.sv
verification/csr_tb.sv

/* src/csr_counters.sv */
// Machine cycle and instret counters

`timescale 1ns/1ps

module csr_counters
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               wr_en,
   input  csr_pkg::csr_addr_t wr_addr,
   input  csr_pkg::csr_data_t wr_data,
   input  logic               retire,
   csr_state_if.cntr          st
);
   import csr_pkg::*;

   cntr_t     cycle_q;
   cntr_t     instret_q;
   csr_data_t inhibit_q;
   cntr_t     cycle_d;
   cntr_t     instret_d;
   csr_data_t inhibit_masked;
   csr_data_t inhibit_wr;

   // ----------------------------------------
   // write decode
   // ----------------------------------------
   logic wr_cyc_lo;
   logic wr_cyc_hi;
   logic wr_ins_lo;
   logic wr_ins_hi;
   logic wr_inhibit;

   assign wr_cyc_lo  = wr_en && (wr_addr == addr_mcycle);
   assign wr_cyc_hi  = wr_en && (wr_addr == addr_mcycleh);
   assign wr_ins_lo  = wr_en && (wr_addr == addr_minstret);
   assign wr_ins_hi  = wr_en && (wr_addr == addr_minstreth);
   assign wr_inhibit = wr_en && (wr_addr == addr_mcountinhibit);

   assign inhibit_masked = wr_data & cntr_en_wmask;
   // there is no time counter here, so its inhibit bit stays zero
   assign inhibit_wr = {inhibit_masked[xlen-1:2], 1'b0, inhibit_masked[0]};

   // ----------------------------------------
   // next counter values
   // ----------------------------------------
   always_comb
   begin
      // a half-word write replaces this cycle's increment
      if (wr_cyc_lo)
         cycle_d = {cycle_q[2*xlen-1:xlen], wr_data};
      else if (wr_cyc_hi)
         cycle_d = {wr_data, cycle_q[xlen-1:0]};
      else if (!inhibit_q[0])
         cycle_d = cycle_q + 1'b1;
      else
         cycle_d = cycle_q;

      // instret only moves on a retire pulse
      if (wr_ins_lo)
         instret_d = {instret_q[2*xlen-1:xlen], wr_data};
      else if (wr_ins_hi)
         instret_d = {wr_data, instret_q[xlen-1:0]};
      else if (retire && !inhibit_q[2])
         instret_d = instret_q + 1'b1;
      else
         instret_d = instret_q;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cycle_q   <= '0;
         instret_q <= '0;
         inhibit_q <= '0;
      end
      else
      begin
         cycle_q   <= cycle_d;
         instret_q <= instret_d;
         if (wr_inhibit)
            inhibit_q <= inhibit_wr;
      end
   end

   // export to the read side
   assign st.mcycle        = cycle_q;
   assign st.minstret      = instret_q;
   assign st.mcountinhibit = inhibit_q;

endmodule

/* src/csr_mregs.sv */
// Machine trap and status registers

`timescale 1ns/1ps

module csr_mregs
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               wr_en,
   input  csr_pkg::csr_addr_t wr_addr,
   input  csr_pkg::csr_data_t wr_data,
   csr_state_if.regs          st
);
   import csr_pkg::*;

   csr_data_t mstatus_q;
   csr_data_t mie_q;
   csr_data_t mtvec_q;
   csr_data_t mcounteren_q;
   csr_data_t mscratch_q;
   csr_data_t mepc_q;
   csr_data_t mcause_q;
   csr_data_t mtval_q;

   // ----------------------------------------
   // mstatus write value
   // ----------------------------------------
   logic [1:0] mpp_new;
   logic       mpp_legal;
   csr_data_t  mstatus_wr;

   // mpp sits in bits 12:11
   assign mpp_new = wr_data[12:11];
   // only M and U exist in this core
   assign mpp_legal = (mpp_new == m_mode) || (mpp_new == u_mode);

   always_comb
   begin
      mstatus_wr = wr_data & mstatus_wmask;
      // illegal mpp keeps the previous value
      if (!mpp_legal)
         mstatus_wr[12:11] = mstatus_q[12:11];
   end

   // ----------------------------------------
   // register writes
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         mstatus_q    <= '0;
         mie_q        <= '0;
         mtvec_q      <= '0;
         mcounteren_q <= '0;
         mscratch_q   <= '0;
         mepc_q       <= '0;
         mcause_q     <= '0;
         mtval_q      <= '0;
      end
      else if (wr_en)
      begin
         // other addresses belong elsewhere or are read-only
         case (wr_addr)
            addr_mstatus:    mstatus_q    <= mstatus_wr;
            addr_mie:        mie_q        <= wr_data & mie_wmask;
            // mode field keeps bit 1 clear: direct or vectored only
            addr_mtvec:      mtvec_q      <= {wr_data[xlen-1:2], 1'b0, wr_data[0]};
            addr_mcounteren: mcounteren_q <= wr_data & cntr_en_wmask;
            addr_mscratch:   mscratch_q   <= wr_data;
            // full value kept, low bits masked on read
            addr_mepc:       mepc_q       <= wr_data;
            addr_mcause:     mcause_q     <= wr_data;
            addr_mtval:      mtval_q      <= wr_data;
            default:         ;
         endcase
      end
   end

   // export to the read side
   assign st.mstatus    = mstatus_q;
   assign st.mie        = mie_q;
   assign st.mtvec      = mtvec_q;
   assign st.mcounteren = mcounteren_q;
   assign st.mscratch   = mscratch_q;
   assign st.mepc       = mepc_q;
   assign st.mcause     = mcause_q;
   assign st.mtval      = mtval_q;

endmodule

/* src/csr_pkg.sv */
// CSR block definitions

package csr_pkg;

   // ----------------------------------------
   // widths and types
   // ----------------------------------------
   localparam int xlen = 32;

   typedef logic [11:0]       csr_addr_t;
   typedef logic [xlen-1:0]   csr_data_t;
   typedef logic [2*xlen-1:0] cntr_t;

   // privilege levels, encoding 2 is reserved
   typedef enum logic [1:0]
   {
      u_mode = 2'd0,
      s_mode = 2'd1,
      m_mode = 2'd3
   } priv_mode_t;

   // ----------------------------------------
   // CSR addresses
   // ----------------------------------------
   // machine status and setup
   localparam csr_addr_t addr_mstatus       = 12'h300;
   localparam csr_addr_t addr_misa          = 12'h301;
   localparam csr_addr_t addr_mie           = 12'h304;
   localparam csr_addr_t addr_mtvec         = 12'h305;
   localparam csr_addr_t addr_mcounteren    = 12'h306;
   localparam csr_addr_t addr_mcountinhibit = 12'h320;
   // machine trap handling
   localparam csr_addr_t addr_mscratch      = 12'h340;
   localparam csr_addr_t addr_mepc          = 12'h341;
   localparam csr_addr_t addr_mcause        = 12'h342;
   localparam csr_addr_t addr_mtval         = 12'h343;
   // machine counters, low and high halves
   localparam csr_addr_t addr_mcycle        = 12'hB00;
   localparam csr_addr_t addr_minstret      = 12'hB02;
   localparam csr_addr_t addr_mcycleh       = 12'hB80;
   localparam csr_addr_t addr_minstreth     = 12'hB82;
   // read-only user aliases
   localparam csr_addr_t addr_cycle         = 12'hC00;
   localparam csr_addr_t addr_time          = 12'hC01;
   localparam csr_addr_t addr_instret       = 12'hC02;
   localparam csr_addr_t addr_cycleh        = 12'hC80;
   localparam csr_addr_t addr_timeh         = 12'hC81;
   localparam csr_addr_t addr_instreth      = 12'hC82;
   // information registers
   localparam csr_addr_t addr_mvendorid     = 12'hF11;
   localparam csr_addr_t addr_marchid       = 12'hF12;
   localparam csr_addr_t addr_mimpid        = 12'hF13;
   localparam csr_addr_t addr_mhartid       = 12'hF14;

   // ----------------------------------------
   // masks and fixed values
   // ----------------------------------------
   // mstatus: mie (3), mpie (7), mpp (12:11)
   localparam csr_data_t mstatus_wmask = 32'h0000_1888;
   // mie: msie (3), mtie (7), meie (11)
   localparam csr_data_t mie_wmask     = 32'h0000_0888;
   // cy, tm, ir enables
   localparam csr_data_t cntr_en_wmask = 32'h0000_0007;
   // 32-bit aligned instructions only
   localparam csr_data_t epc_rmask     = 32'hFFFF_FFFC;

   // mxl = 1 (RV32), extensions I, M and U
   localparam csr_data_t misa_value      = 32'h4010_1100;
   localparam csr_data_t mvendorid_value = 32'h0000_0000;
   localparam csr_data_t marchid_value   = 32'h0000_0000;
   localparam csr_data_t mimpid_value    = 32'h0000_0001;

endpackage

/* src/csr_rd_mux.sv */
// CSR read decoder

`timescale 1ns/1ps

module csr_rd_mux #(
   parameter csr_pkg::csr_data_t HART_ID
)
(
   input  csr_pkg::csr_addr_t  rd_addr,
   input  csr_pkg::priv_mode_t mode,
   input  csr_pkg::cntr_t      mtime,
   csr_state_if.mux            st,
   output csr_pkg::csr_data_t  rd_data,
   output logic                rd_avail
);
   import csr_pkg::*;

   logic      cntr_av;
   logic      is_alias;
   logic      hit;
   csr_data_t data_sel;

   // ----------------------------------------
   // counter alias privilege
   // ----------------------------------------
   always_comb
   begin
      case (mode)
         m_mode:  cntr_av = 1'b1;
         // mcounteren bit picked by the low address bits
         u_mode:  cntr_av = st.mcounteren[rd_addr[4:0]];
         // no S-mode counter path in this core
         s_mode:  cntr_av = 1'b0;
         // reserved encoding
         default: cntr_av = 1'b0;
      endcase
   end

   // C00-C02 and C80-C82
   assign is_alias = (rd_addr == addr_cycle)  || (rd_addr == addr_time)  ||
                     (rd_addr == addr_instret) || (rd_addr == addr_cycleh) ||
                     (rd_addr == addr_timeh)  || (rd_addr == addr_instreth);

   // ----------------------------------------
   // address decode and data select
   // ----------------------------------------
   always_comb
   begin
      hit      = 1'b1;
      data_sel = '0;
      case (rd_addr)
         // status and setup
         addr_mstatus:       data_sel = st.mstatus;
         addr_misa:          data_sel = misa_value;
         addr_mie:           data_sel = st.mie;
         addr_mtvec:         data_sel = st.mtvec;
         addr_mcounteren:    data_sel = st.mcounteren;
         addr_mcountinhibit: data_sel = st.mcountinhibit;
         // trap handling
         addr_mscratch:      data_sel = st.mscratch;
         addr_mepc:          data_sel = st.mepc & epc_rmask;
         addr_mcause:        data_sel = st.mcause;
         addr_mtval:         data_sel = st.mtval;
         // machine counters
         addr_mcycle:        data_sel = st.mcycle[xlen-1:0];
         addr_mcycleh:       data_sel = st.mcycle[2*xlen-1:xlen];
         addr_minstret:      data_sel = st.minstret[xlen-1:0];
         addr_minstreth:     data_sel = st.minstret[2*xlen-1:xlen];
         // user aliases, gated below
         addr_cycle:         data_sel = st.mcycle[xlen-1:0];
         addr_time:          data_sel = mtime[xlen-1:0];
         addr_instret:       data_sel = st.minstret[xlen-1:0];
         addr_cycleh:        data_sel = st.mcycle[2*xlen-1:xlen];
         addr_timeh:         data_sel = mtime[2*xlen-1:xlen];
         addr_instreth:      data_sel = st.minstret[2*xlen-1:xlen];
         // information registers
         addr_mvendorid:     data_sel = mvendorid_value;
         addr_marchid:       data_sel = marchid_value;
         addr_mimpid:        data_sel = mimpid_value;
         addr_mhartid:       data_sel = HART_ID;
         default:            hit      = 1'b0;
      endcase
   end

   // ----------------------------------------
   // outputs
   // ----------------------------------------
   // aliases need the privilege check, everything else only has to exist
   assign rd_avail = hit && (!is_alias || cntr_av);
   // nothing leaks out of an unavailable read
   assign rd_data  = rd_avail ? data_sel : '0;

endmodule

/* src/csr_state_if.sv */
// CSR state bundle

`timescale 1ns/1ps

interface csr_state_if;
   import csr_pkg::*;

   // trap and status registers
   csr_data_t mstatus;
   csr_data_t mie;
   csr_data_t mtvec;
   csr_data_t mcounteren;
   csr_data_t mscratch;
   csr_data_t mepc;
   csr_data_t mcause;
   csr_data_t mtval;

   // counters and their inhibit bits
   cntr_t     mcycle;
   cntr_t     minstret;
   csr_data_t mcountinhibit;

   // register file side
   modport regs (output mstatus, mie, mtvec, mcounteren, mscratch, mepc, mcause, mtval);
   // counter side
   modport cntr (output mcycle, minstret, mcountinhibit);
   // read decoder sees everything
   modport mux (input mstatus, mie, mtvec, mcounteren, mscratch, mepc, mcause, mtval,
                      mcycle, minstret, mcountinhibit);

endinterface

/* src/csr_top.sv */
// Machine-mode CSR block

`timescale 1ns/1ps

module csr_top #(
   parameter csr_pkg::csr_data_t HART_ID = 32'd0
)
(
   input  logic                clk,
   input  logic                arst_n,
   // combinational read port
   input  csr_pkg::csr_addr_t  rd_addr,
   output csr_pkg::csr_data_t  rd_data,
   output logic                rd_avail,
   // write strobe, data is the final value
   input  logic                wr_en,
   input  csr_pkg::csr_addr_t  wr_addr,
   input  csr_pkg::csr_data_t  wr_data,
   // current privilege
   input  csr_pkg::priv_mode_t mode,
   // one pulse per retired instruction
   input  logic                retire,
   // platform timer
   input  csr_pkg::cntr_t      mtime
);

   // ----------------------------------------
   // shared register state
   // ----------------------------------------
   csr_state_if st ();

   // trap and status registers
   csr_mregs u_mregs
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .st      (st.regs)
   );

   // cycle and instret counters
   csr_counters u_counters
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .retire  (retire),
      .st      (st.cntr)
   );

   // ----------------------------------------
   // read path
   // ----------------------------------------
   csr_rd_mux #(
      .HART_ID (HART_ID)
   ) u_rd_mux
   (
      .rd_addr  (rd_addr),
      .mode     (mode),
      .mtime    (mtime),
      .st       (st.mux),
      .rd_data  (rd_data),
      .rd_avail (rd_avail)
   );

endmodule

/* verification/csr_tb.sv */
// CSR block testbench

`timescale 1ns/1ps

module csr_tb;
   import csr_pkg::*;

   localparam int clk_period  = 10;
   // rough length of all tests in cycles
   // the watchdog allows twice this
   localparam int test_cycles = 1000;

   // every address that exists
   localparam csr_addr_t known_addrs [24] = '{
      addr_mstatus, addr_misa, addr_mie, addr_mtvec, addr_mcounteren, addr_mcountinhibit,
      addr_mscratch, addr_mepc, addr_mcause, addr_mtval,
      addr_mcycle, addr_mcycleh, addr_minstret, addr_minstreth,
      addr_cycle, addr_time, addr_instret, addr_cycleh, addr_timeh, addr_instreth,
      addr_mvendorid, addr_marchid, addr_mimpid, addr_mhartid
   };
   // writable registers
   localparam csr_addr_t rw_addrs [9] = '{
      addr_mscratch, addr_mcause, addr_mtval, addr_mtvec, addr_mepc,
      addr_mstatus, addr_mie, addr_mcounteren, addr_mcountinhibit
   };
   // user counter aliases
   localparam csr_addr_t alias_addrs [6] = '{
      addr_cycle, addr_time, addr_instret, addr_cycleh, addr_timeh, addr_instreth
   };

   logic       clk;
   logic       arst_n;
   csr_addr_t  rd_addr;
   csr_data_t  rd_data;
   logic       rd_avail;
   logic       wr_en;
   csr_addr_t  wr_addr;
   csr_data_t  wr_data;
   priv_mode_t mode;
   logic       retire;
   cntr_t      mtime;

   // reference copy of the register state
   csr_data_t ref_mstatus;
   csr_data_t ref_mie;
   csr_data_t ref_mtvec;
   csr_data_t ref_mcounteren;
   csr_data_t ref_mscratch;
   csr_data_t ref_mepc;
   csr_data_t ref_mcause;
   csr_data_t ref_mtval;
   csr_data_t ref_inhibit;
   cntr_t     ref_cycle;
   cntr_t     ref_instret;
   csr_data_t exp_data;
   logic      exp_avail;
   logic      exp_alias;
   logic [15:0] lfsr;

   csr_top #(
      .HART_ID (32'd5)
   ) dut
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .rd_avail (rd_avail),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .mode     (mode),
      .retire   (retire),
      .mtime    (mtime)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   always @(posedge clk or negedge arst_n)
   begin : ref_update
      cntr_t      nxt_cycle;
      cntr_t      nxt_instret;
      logic [1:0] mpp_req;
      if (!arst_n)
      begin
         ref_mstatus    <= '0;
         ref_mie        <= '0;
         ref_mtvec      <= '0;
         ref_mcounteren <= '0;
         ref_mscratch   <= '0;
         ref_mepc       <= '0;
         ref_mcause     <= '0;
         ref_mtval      <= '0;
         ref_inhibit    <= '0;
         ref_cycle      <= '0;
         ref_instret    <= '0;
      end
      else
      begin
         nxt_cycle   = ref_inhibit[0] ? ref_cycle : ref_cycle + 64'd1;
         nxt_instret = (retire && !ref_inhibit[2]) ? ref_instret + 64'd1 : ref_instret;
         mpp_req     = wr_data[12:11];
         if (wr_en)
         begin
            case (wr_addr)
               addr_mstatus:
               begin
                  ref_mstatus <= wr_data & mstatus_wmask;
                  // reserved mpp values keep the old field
                  if (mpp_req == 2'b01 || mpp_req == 2'b10)
                     ref_mstatus[12:11] <= ref_mstatus[12:11];
               end
               addr_mie:           ref_mie        <= wr_data & mie_wmask;
               addr_mtvec:         ref_mtvec      <= wr_data & ~32'h0000_0002;
               addr_mcounteren:    ref_mcounteren <= wr_data & cntr_en_wmask;
               addr_mscratch:      ref_mscratch   <= wr_data;
               addr_mepc:          ref_mepc       <= wr_data;
               addr_mcause:        ref_mcause     <= wr_data;
               addr_mtval:         ref_mtval      <= wr_data;
               // only cycle and instret inhibit bits
               addr_mcountinhibit: ref_inhibit    <= wr_data & 32'h0000_0005;
               // a half write beats the increment
               addr_mcycle:        nxt_cycle   = {ref_cycle[63:32], wr_data};
               addr_mcycleh:       nxt_cycle   = {wr_data, ref_cycle[31:0]};
               addr_minstret:      nxt_instret = {ref_instret[63:32], wr_data};
               addr_minstreth:     nxt_instret = {wr_data, ref_instret[31:0]};
               default:            ;
            endcase
         end
         ref_cycle   <= nxt_cycle;
         ref_instret <= nxt_instret;
      end
   end

   // expected read response
   always_comb
   begin
      exp_avail = 1'b1;
      exp_data  = '0;
      // C00-C02 and C80-C82
      exp_alias = (rd_addr[11:8] == 4'hC) && (rd_addr[6:2] == 5'd0) && (rd_addr[1:0] != 2'd3);
      case (rd_addr)
         addr_mstatus:       exp_data = ref_mstatus;
         addr_misa:          exp_data = misa_value;
         addr_mie:           exp_data = ref_mie;
         addr_mtvec:         exp_data = ref_mtvec;
         addr_mcounteren:    exp_data = ref_mcounteren;
         addr_mcountinhibit: exp_data = ref_inhibit;
         addr_mscratch:      exp_data = ref_mscratch;
         addr_mepc:          exp_data = ref_mepc & 32'hFFFF_FFFC;
         addr_mcause:        exp_data = ref_mcause;
         addr_mtval:         exp_data = ref_mtval;
         addr_mcycle,
         addr_cycle:         exp_data = ref_cycle[31:0];
         addr_mcycleh,
         addr_cycleh:        exp_data = ref_cycle[63:32];
         addr_minstret,
         addr_instret:       exp_data = ref_instret[31:0];
         addr_minstreth,
         addr_instreth:      exp_data = ref_instret[63:32];
         addr_time:          exp_data = mtime[31:0];
         addr_timeh:         exp_data = mtime[63:32];
         addr_mvendorid:     exp_data = mvendorid_value;
         addr_marchid:       exp_data = marchid_value;
         addr_mimpid:        exp_data = mimpid_value;
         addr_mhartid:       exp_data = 32'd5;
         default:            exp_avail = 1'b0;
      endcase
      // aliases are open in M, follow mcounteren in U and stay closed otherwise
      if (exp_alias && mode != m_mode)
      begin
         if (mode != u_mode || !ref_mcounteren[rd_addr[1:0]])
            exp_avail = 1'b0;
      end
      if (!exp_avail)
         exp_data = '0;
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   avail_check: assert property (@(posedge clk) disable iff (!arst_n) rd_avail == exp_avail)
      else mismatch("rd_avail", $sampled(exp_avail), $sampled(rd_avail));
   data_check: assert property (@(posedge clk) disable iff (!arst_n) rd_data == exp_data)
      else mismatch("rd_data", $sampled(exp_data), $sampled(rd_data));
   zero_check: assert property (@(posedge clk) disable iff (!arst_n) rd_avail || rd_data == '0)
      else give_up("rd_data is non-zero on a read that is not available");

   task automatic give_up(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic mismatch(input string name, input logic [63:0] expv, input logic [63:0] actv);
      $display("error at %0d ns: %s expected %0h actual %0h", $time, name, expv, actv);
      give_up("value differs from the expected one");
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit
   task automatic random_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic write_csr(input csr_addr_t a, input csr_data_t d);
      wr_en   = 1'b1;
      wr_addr = a;
      wr_data = d;
      idle(1);
      wr_en   = 1'b0;
   endtask

   // sample 1 ns after driving and hold the address over one checked edge
   task automatic read_csr(input csr_addr_t a, output csr_data_t d);
      rd_addr = a;
      #1;
      d = rd_data;
      idle(1);
   endtask

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   initial
   begin : stimulus
      csr_data_t   a;
      csr_data_t   b;
      logic [63:0] r;
      int          pulses;
      lfsr    = 16'd79;
      arst_n  = 1'b0;
      rd_addr = '0;
      wr_en   = 1'b0;
      wr_addr = '0;
      wr_data = '0;
      mode    = m_mode;
      retire  = 1'b0;
      mtime   = '0;
      repeat (5) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // every address after reset plus an unknown one (stval)
      for (int i = 0; i < $size(known_addrs); i++)
         read_csr(known_addrs[i], a);
      read_csr(12'h143, a);
      if (rd_avail || a != '0)
         give_up("unknown address 143 reads as available or non-zero");

      // random write and read back
      for (int k = 0; k < 4; k++)
      begin
         for (int i = 0; i < $size(rw_addrs); i++)
         begin
            random_bits(32, r);
            write_csr(rw_addrs[i], r[31:0]);
            read_csr(rw_addrs[i], a);
         end
      end
      // legal mpp then a reserved one
      random_bits(32, r);
      write_csr(addr_mstatus, r[31:0] | 32'h0000_1800);
      random_bits(32, r);
      write_csr(addr_mstatus, (r[31:0] & ~32'h0000_1800) | 32'h0000_1000);
      read_csr(addr_mstatus, a);
      assert (a[12:11] == 2'b11) else mismatch("mstatus.mpp", 64'd3, a[12:11]);
      // read-only targets
      random_bits(32, r);
      write_csr(addr_misa, r[31:0]);
      write_csr(addr_mhartid, r[31:0]);
      write_csr(addr_cycle, r[31:0]);
      read_csr(addr_misa, a);
      read_csr(addr_mhartid, a);
      read_csr(addr_cycle, a);

      // cycle counting over 7 edges
      write_csr(addr_mcountinhibit, 32'h0);
      read_csr(addr_mcycle, a);
      idle(6);
      read_csr(addr_mcycle, b);
      assert (b - a == 32'd7) else mismatch("mcycle delta", 64'd7, b - a);
      write_csr(addr_mcountinhibit, 32'h1);
      read_csr(addr_mcycle, a);
      idle(6);
      read_csr(addr_mcycle, b);
      assert (b == a) else mismatch("mcycle inhibited", a, b);
      // low half wraps into the high half
      write_csr(addr_mcountinhibit, 32'h0);
      write_csr(addr_mcycleh, 32'h0000_0041);
      write_csr(addr_mcycle, 32'hFFFF_FFF8);
      for (int i = 0; i < 6; i++)
      begin
         read_csr(addr_mcycle, a);
         read_csr(addr_mcycleh, b);
      end
      assert (b == 32'h42) else mismatch("mcycleh", 64'h42, b);

      // instret follows random retire pulses
      read_csr(addr_minstret, a);
      pulses = 0;
      for (int i = 0; i < 20; i++)
      begin
         random_bits(1, r);
         retire = r[0];
         pulses = pulses + int'(r[0]);
         idle(1);
      end
      retire = 1'b0;
      read_csr(addr_minstret, b);
      assert (b - a == csr_data_t'(pulses)) else mismatch("minstret delta", pulses, b - a);
      write_csr(addr_mcountinhibit, 32'h4);
      retire = 1'b1;
      idle(5);
      retire = 1'b0;
      read_csr(addr_minstret, a);
      // writes land together with retire pulses
      write_csr(addr_mcountinhibit, 32'h0);
      retire = 1'b1;
      write_csr(addr_minstret, 32'h0000_0100);
      write_csr(addr_minstreth, 32'h0000_0003);
      retire = 1'b0;
      read_csr(addr_minstret, a);
      assert (a == 32'h100) else mismatch("minstret", 64'h100, a);
      read_csr(addr_minstreth, b);
      assert (b == 32'h3) else mismatch("minstreth", 64'h3, b);

      // aliases in M mode
      random_bits(64, r);
      mtime = r;
      for (int i = 0; i < $size(alias_addrs); i++)
         read_csr(alias_addrs[i], a);
      // U mode under every mcounteren value
      for (int en = 0; en < 8; en++)
      begin
         mode = m_mode;
         write_csr(addr_mcounteren, csr_data_t'(en));
         mode = u_mode;
         random_bits(64, r);
         mtime = r;
         for (int i = 0; i < $size(alias_addrs); i++)
            read_csr(alias_addrs[i], a);
         read_csr(addr_mscratch, a);
      end
      // S mode and the reserved encoding
      mode = s_mode;
      for (int i = 0; i < $size(alias_addrs); i++)
         read_csr(alias_addrs[i], a);
      read_csr(addr_mstatus, a);
      read_csr(addr_mcycle, a);
      mode = priv_mode_t'(2'd2);
      read_csr(addr_cycle, a);
      read_csr(addr_mhartid, a);

      mode = m_mode;
      idle(2);
      $display(">>> PASS");
      $finish;
   end

   initial
   begin : watchdog
      #(2 * test_cycles * clk_period);
      give_up("timeout: the tests did not finish in time");
   end

endmodule
